/* hdl/frv_pkg.sv */
package frv_pkg;

  // ------------------------------------------------------------------------
  // Widths
  // ------------------------------------------------------------------------
  localparam int XLEN = 32;                  // RV32 data word

  typedef logic [XLEN-1:0] xword_t;           // Operands, results, pc
  typedef logic [4:0]      reg_idx_t;         // GPR index x0..x31

  // ------------------------------------------------------------------------
  // Micro-op and unit codes
  // ------------------------------------------------------------------------
  typedef logic [4:0] uop_t;

  localparam uop_t UOP_ADD  = 5'd0;
  localparam uop_t UOP_SUB  = 5'd1;
  localparam uop_t UOP_AND  = 5'd2;
  localparam uop_t UOP_OR   = 5'd3;
  localparam uop_t UOP_XOR  = 5'd4;
  localparam uop_t UOP_SLT  = 5'd5;           // Signed less than
  localparam uop_t UOP_SLTU = 5'd6;           // Unsigned less than
  localparam uop_t UOP_SLL  = 5'd7;
  localparam uop_t UOP_SRL  = 5'd8;
  localparam uop_t UOP_SRA  = 5'd9;
  localparam uop_t UOP_BEQ  = 5'd16;          // Control flow codes
  localparam uop_t UOP_BNE  = 5'd17;
  localparam uop_t UOP_BLT  = 5'd18;
  localparam uop_t UOP_BGE  = 5'd19;
  localparam uop_t UOP_JAL  = 5'd20;

  typedef logic [4:0] fu_t;                   // One-hot unit select

  localparam int FU_ALU = 0;                  // Bit position
  localparam int FU_CFU = 1;                  // Bit position

  // ------------------------------------------------------------------------
  // Operand sources, remaining bits reserved
  // ------------------------------------------------------------------------
  typedef logic [7:0] opr_src_t;

  localparam int OPR_A_RS1 = 0;
  localparam int OPR_A_PC  = 1;
  localparam int OPR_B_RS2 = 2;
  localparam int OPR_B_IMM = 3;

  // Writeback control-flow request FSM
  typedef enum logic [1:0] {
    WB_RUN,                                   // Items retire freely
    WB_REQ,                                   // cf_req up, waiting for ack
    WB_REL                                    // Ack seen, waiting for it to drop
  } wb_state_t;

endpackage

/* hdl/frv_stage_if.sv */
`timescale 1ns/1ps

interface frv_stage_if;

  logic              p_valid;                 // Dispatch register holds an item
  logic              p_busy;                  // Execute cannot take it
  frv_pkg::reg_idx_t rd;                      // Destination register
  frv_pkg::xword_t   opr_a;
  frv_pkg::xword_t   opr_b;
  frv_pkg::xword_t   opr_c;                   // Branch target
  frv_pkg::xword_t   pc;
  frv_pkg::uop_t     uop;
  frv_pkg::fu_t      fu;

  modport up (
    output p_valid, rd, opr_a, opr_b, opr_c, pc, uop, fu,
    input  p_busy
  );

  modport down (
    input  p_valid, rd, opr_a, opr_b, opr_c, pc, uop, fu,
    output p_busy
  );

endinterface

/* hdl/frv_result_if.sv */
`timescale 1ns/1ps

interface frv_result_if;

  logic              p_valid;                 // Result register holds an item
  logic              p_busy;                  // Writeback stalled
  frv_pkg::reg_idx_t rd;
  frv_pkg::xword_t   wdata;                   // ALU result or link value
  logic              wen;                     // GPR write wanted
  logic              taken;                   // Control flow change
  frv_pkg::xword_t   target;
  frv_pkg::xword_t   pc;

  modport up (
    output p_valid, rd, wdata, wen, taken, target, pc,
    input  p_busy
  );

  modport down (
    input  p_valid, rd, wdata, wen, taken, target, pc,
    output p_busy
  );

endinterface

/* hdl/frv_gprs.sv */
`timescale 1ns/1ps

module frv_gprs (
  input  logic              g_clk,
  input  logic              reset,
  input  frv_pkg::reg_idx_t rs1_addr,
  input  frv_pkg::reg_idx_t rs2_addr,
  output frv_pkg::xword_t   rs1_data,
  output frv_pkg::xword_t   rs2_data,
  input  logic              gpr_wen,
  input  frv_pkg::reg_idx_t gpr_rd,
  input  frv_pkg::xword_t   gpr_wdata
);

  frv_pkg::xword_t regs [1:31];               // x0 has no storage

  always_ff @(posedge g_clk) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (gpr_wen && gpr_rd != '0) begin  // Writes to x0 dropped
      regs[gpr_rd] <= gpr_wdata;
    end
  end

  // Combinational reads, x0 is hardwired zero
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

/* hdl/frv_pipeline_dispatch.sv */
`timescale 1ns/1ps

module frv_pipeline_dispatch (
  input  logic               g_clk,
  input  logic               reset,
  output logic               s2_p_busy,     // Dispatch register full and stuck
  input  logic               s2_p_valid,
  input  frv_pkg::reg_idx_t  s2_rd,
  input  frv_pkg::reg_idx_t  s2_rs1,
  input  frv_pkg::reg_idx_t  s2_rs2,
  input  frv_pkg::xword_t    s2_imm,
  input  frv_pkg::xword_t    s2_pc,
  input  frv_pkg::uop_t      s2_uop,
  input  frv_pkg::fu_t       s2_fu,
  input  frv_pkg::opr_src_t  s2_opr_src,
  output frv_pkg::reg_idx_t  rs1_addr,      // GPR read ports
  output frv_pkg::reg_idx_t  rs2_addr,
  input  frv_pkg::xword_t    rs1_data,
  input  frv_pkg::xword_t    rs2_data,
  input  logic               fwd_s3_wen,    // Result of item now in execute
  input  frv_pkg::reg_idx_t  fwd_s3_rd,
  input  frv_pkg::xword_t    fwd_s3_wdata,
  input  logic               fwd_s4_wen,    // Result register of execute
  input  frv_pkg::reg_idx_t  fwd_s4_rd,
  input  frv_pkg::xword_t    fwd_s4_wdata,
  frv_stage_if.up            s3
);

  frv_pkg::xword_t rs1_val;                   // Forwarded source values
  frv_pkg::xword_t rs2_val;
  frv_pkg::xword_t opr_a;
  frv_pkg::xword_t opr_b;
  logic            accept;
  logic            s3_fire;

  // Youngest producer wins, x0 always zero
  function automatic frv_pkg::xword_t resolve(
    input frv_pkg::reg_idx_t idx,
    input frv_pkg::xword_t   rf_data
  );
    if (idx == '0) begin
      return '0;
    end else if (fwd_s3_wen && fwd_s3_rd == idx) begin
      return fwd_s3_wdata;
    end else if (fwd_s4_wen && fwd_s4_rd == idx) begin
      return fwd_s4_wdata;
    end
    return rf_data;
  endfunction

  assign rs1_addr = s2_rs1;
  assign rs2_addr = s2_rs2;

  always_comb begin
    rs1_val = resolve(s2_rs1, rs1_data);
    rs2_val = resolve(s2_rs2, rs2_data);
  end

  // ------------------------------------------------------------------------
  // Operand selection
  // ------------------------------------------------------------------------
  always_comb begin
    opr_a = '0;                               // Neither source bit set
    if (s2_opr_src[frv_pkg::OPR_A_RS1]) begin
      opr_a = rs1_val;
    end else if (s2_opr_src[frv_pkg::OPR_A_PC]) begin
      opr_a = s2_pc;
    end
    opr_b = '0;
    if (s2_opr_src[frv_pkg::OPR_B_RS2]) begin
      opr_b = rs2_val;
    end else if (s2_opr_src[frv_pkg::OPR_B_IMM]) begin
      opr_b = s2_imm;
    end
  end

  // ------------------------------------------------------------------------
  // Stage handshake and operand register
  // ------------------------------------------------------------------------
  assign s3_fire   = s3.p_valid && !s3.p_busy;      // Item moves to execute
  assign s2_p_busy = s3.p_valid && s3.p_busy;       // Free if empty or leaving
  assign accept    = s2_p_valid && !s2_p_busy;

  always_ff @(posedge g_clk) begin
    if (reset) begin
      s3.p_valid <= 1'b0;
    end else if (accept) begin
      s3.p_valid <= 1'b1;
    end else if (s3_fire) begin
      s3.p_valid <= 1'b0;
    end
  end

  always_ff @(posedge g_clk) begin
    if (accept) begin                         // Payload only
      s3.rd    <= s2_rd;
      s3.opr_a <= opr_a;
      s3.opr_b <= opr_b;
      s3.opr_c <= s2_pc + s2_imm;             // Branch or jump target
      s3.pc    <= s2_pc;
      s3.uop   <= s2_uop;
      s3.fu    <= s2_fu;
    end
  end

endmodule

/* hdl/frv_pipeline_execute.sv */
`timescale 1ns/1ps

module frv_pipeline_execute (
  input  logic              g_clk,
  input  logic              reset,
  frv_stage_if.down         s3,
  frv_result_if.up          s4,
  output logic              fwd_s3_wen,      // Combinational result
  output frv_pkg::reg_idx_t fwd_s3_rd,
  output frv_pkg::xword_t   fwd_s3_wdata,
  output logic              fwd_s4_wen,      // Registered result
  output frv_pkg::reg_idx_t fwd_s4_rd,
  output frv_pkg::xword_t   fwd_s4_wdata
);

  frv_pkg::xword_t alu_result;
  frv_pkg::xword_t wdata;
  logic            cond;                      // Branch condition holds
  logic            is_cfu;
  logic            wen;
  logic            taken;
  logic            s3_fire;
  logic            s4_fire;

  // ------------------------------------------------------------------------
  // ALU
  // ------------------------------------------------------------------------
  always_comb begin
    case (s3.uop)
      frv_pkg::UOP_ADD:  alu_result = s3.opr_a + s3.opr_b;
      frv_pkg::UOP_SUB:  alu_result = s3.opr_a - s3.opr_b;
      frv_pkg::UOP_AND:  alu_result = s3.opr_a & s3.opr_b;
      frv_pkg::UOP_OR:   alu_result = s3.opr_a | s3.opr_b;
      frv_pkg::UOP_XOR:  alu_result = s3.opr_a ^ s3.opr_b;
      frv_pkg::UOP_SLT:  alu_result = {31'b0, $signed(s3.opr_a) < $signed(s3.opr_b)};
      frv_pkg::UOP_SLTU: alu_result = {31'b0, s3.opr_a < s3.opr_b};
      frv_pkg::UOP_SLL:  alu_result = s3.opr_a << s3.opr_b[4:0];
      frv_pkg::UOP_SRL:  alu_result = s3.opr_a >> s3.opr_b[4:0];
      frv_pkg::UOP_SRA:  alu_result = $signed(s3.opr_a) >>> s3.opr_b[4:0];
      default:           alu_result = '0;
    endcase
  end

  // Branch compare, JAL always taken
  always_comb begin
    case (s3.uop)
      frv_pkg::UOP_BEQ: cond = s3.opr_a == s3.opr_b;
      frv_pkg::UOP_BNE: cond = s3.opr_a != s3.opr_b;
      frv_pkg::UOP_BLT: cond = $signed(s3.opr_a) <  $signed(s3.opr_b);
      frv_pkg::UOP_BGE: cond = $signed(s3.opr_a) >= $signed(s3.opr_b);
      frv_pkg::UOP_JAL: cond = 1'b1;
      default:          cond = 1'b0;
    endcase
  end

  assign is_cfu = s3.fu[frv_pkg::FU_CFU];
  assign taken  = is_cfu && cond;
  assign wdata  = is_cfu ? s3.pc + 32'd4 : alu_result;     // Link value for JAL
  assign wen    = (s3.fu[frv_pkg::FU_ALU] || (is_cfu && s3.uop == frv_pkg::UOP_JAL)) &&
                  (s3.rd != '0);

  // ------------------------------------------------------------------------
  // Result register
  // ------------------------------------------------------------------------
  assign s4_fire  = s4.p_valid && !s4.p_busy;
  assign s3.p_busy = s4.p_valid && s4.p_busy;
  assign s3_fire  = s3.p_valid && !s3.p_busy;

  always_ff @(posedge g_clk) begin
    if (reset) begin
      s4.p_valid <= 1'b0;
    end else if (s3_fire) begin
      s4.p_valid <= 1'b1;
    end else if (s4_fire) begin
      s4.p_valid <= 1'b0;
    end
  end

  always_ff @(posedge g_clk) begin
    if (s3_fire) begin
      s4.rd     <= s3.rd;
      s4.wdata  <= wdata;
      s4.wen    <= wen;
      s4.taken  <= taken;
      s4.target <= s3.opr_c;
      s4.pc     <= s3.pc;
    end
  end

  // Forwarding toward dispatch
  assign fwd_s3_wen   = s3.p_valid && wen;
  assign fwd_s3_rd    = s3.rd;
  assign fwd_s3_wdata = wdata;
  assign fwd_s4_wen   = s4.p_valid && s4.wen;
  assign fwd_s4_rd    = s4.rd;
  assign fwd_s4_wdata = s4.wdata;

endmodule

/* hdl/frv_pipeline_writeback.sv */
`timescale 1ns/1ps

module frv_pipeline_writeback (
  input  logic              g_clk,
  input  logic              reset,
  frv_result_if.down        s4,
  output logic              gpr_wen,         // Register file write port
  output frv_pkg::reg_idx_t gpr_rd,
  output frv_pkg::xword_t   gpr_wdata,
  output logic              cf_req,          // Four-phase request
  output frv_pkg::xword_t   cf_target,
  input  logic              cf_ack,
  output logic              trs_valid,       // Retire trace
  output frv_pkg::xword_t   trs_pc,
  output frv_pkg::reg_idx_t trs_rd,
  output frv_pkg::xword_t   trs_wdata,
  output logic              trs_wen
);

  frv_pkg::wb_state_t state;
  logic               cf_pend;               // Taken item at the head
  logic               retire;

  assign cf_pend = s4.p_valid && s4.taken;

  // ------------------------------------------------------------------------
  // Control-flow request FSM
  // ------------------------------------------------------------------------
  always_ff @(posedge g_clk) begin
    if (reset) begin
      state <= frv_pkg::WB_RUN;
    end else begin
      case (state)
        frv_pkg::WB_RUN: if (cf_pend) state <= frv_pkg::WB_REQ;
        frv_pkg::WB_REQ: if (cf_ack)  state <= frv_pkg::WB_REL;  // Item retires here
        frv_pkg::WB_REL: if (!cf_ack) state <= frv_pkg::WB_RUN;  // Ack released
        default:                      state <= frv_pkg::WB_RUN;
      endcase
    end
  end

  // Request goes up in the first cycle the taken item is seen
  assign cf_req    = (state == frv_pkg::WB_RUN && cf_pend) || (state == frv_pkg::WB_REQ);
  assign cf_target = s4.target;              // Held stable by the stall

  always_comb begin
    case (state)
      frv_pkg::WB_RUN: s4.p_busy = cf_pend;
      frv_pkg::WB_REQ: s4.p_busy = !cf_ack;
      default:         s4.p_busy = 1'b1;
    endcase
  end

  // ------------------------------------------------------------------------
  // Retire and register write
  // ------------------------------------------------------------------------
  assign retire    = s4.p_valid && !s4.p_busy;

  assign gpr_wen   = retire && s4.wen;
  assign gpr_rd    = s4.rd;
  assign gpr_wdata = s4.wdata;

  assign trs_valid = retire;
  assign trs_pc    = s4.pc;
  assign trs_rd    = s4.rd;
  assign trs_wdata = s4.wdata;
  assign trs_wen   = s4.wen;                 // Already low for x0

endmodule

/* hdl/frv_pipeline_back.sv */
`timescale 1ns/1ps

module frv_pipeline_back (
  input  logic              g_clk,
  input  logic              reset,
  output logic              s2_p_busy,       // Backend cannot accept
  input  logic              s2_p_valid,
  input  frv_pkg::reg_idx_t s2_rd,
  input  frv_pkg::reg_idx_t s2_rs1,
  input  frv_pkg::reg_idx_t s2_rs2,
  input  frv_pkg::xword_t   s2_imm,
  input  frv_pkg::xword_t   s2_pc,
  input  frv_pkg::uop_t     s2_uop,
  input  frv_pkg::fu_t      s2_fu,
  input  frv_pkg::opr_src_t s2_opr_src,
  output logic              cf_req,          // Control flow change to frontend
  output frv_pkg::xword_t   cf_target,
  input  logic              cf_ack,
  output logic              trs_valid,       // One pulse per retired item
  output frv_pkg::xword_t   trs_pc,
  output frv_pkg::reg_idx_t trs_rd,
  output frv_pkg::xword_t   trs_wdata,
  output logic              trs_wen
);

  // ------------------------------------------------------------------------
  // Inter-stage wiring
  // ------------------------------------------------------------------------
  frv_pkg::reg_idx_t rs1_addr;
  frv_pkg::reg_idx_t rs2_addr;
  frv_pkg::xword_t   rs1_data;
  frv_pkg::xword_t   rs2_data;

  logic              fwd_s3_wen;
  frv_pkg::reg_idx_t fwd_s3_rd;
  frv_pkg::xword_t   fwd_s3_wdata;
  logic              fwd_s4_wen;
  frv_pkg::reg_idx_t fwd_s4_rd;
  frv_pkg::xword_t   fwd_s4_wdata;

  logic              gpr_wen;
  frv_pkg::reg_idx_t gpr_rd;
  frv_pkg::xword_t   gpr_wdata;

  frv_stage_if  s3_if ();                    // Dispatch to execute
  frv_result_if s4_if ();                    // Execute to writeback

  frv_gprs i_gprs (
    .g_clk, .reset,
    .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
    .gpr_wen, .gpr_rd, .gpr_wdata
  );

  frv_pipeline_dispatch i_pipeline_dispatch (
    .g_clk, .reset,
    .s2_p_busy, .s2_p_valid, .s2_rd, .s2_rs1, .s2_rs2, .s2_imm, .s2_pc,
    .s2_uop, .s2_fu, .s2_opr_src,
    .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
    .fwd_s3_wen, .fwd_s3_rd, .fwd_s3_wdata,
    .fwd_s4_wen, .fwd_s4_rd, .fwd_s4_wdata,
    .s3 (s3_if.up)
  );

  frv_pipeline_execute i_pipeline_execute (
    .g_clk, .reset,
    .s3 (s3_if.down),
    .s4 (s4_if.up),
    .fwd_s3_wen, .fwd_s3_rd, .fwd_s3_wdata,
    .fwd_s4_wen, .fwd_s4_rd, .fwd_s4_wdata
  );

  frv_pipeline_writeback i_pipeline_writeback (
    .g_clk, .reset,
    .s4 (s4_if.down),
    .gpr_wen, .gpr_rd, .gpr_wdata,
    .cf_req, .cf_target, .cf_ack,
    .trs_valid, .trs_pc, .trs_rd, .trs_wdata, .trs_wen
  );

endmodule

/* sim/frv_back_checker.sv */
`timescale 1ns/1ps

module frv_back_checker (
  input logic            g_clk,
  input logic            reset,
  input logic            cf_req,
  input logic            cf_ack,
  input frv_pkg::xword_t cf_target,
  input logic            trs_valid
);

  int fail_count = 0;                         // Failed assertion count

  // --------------------------------------------------------------------------
  // Four-phase cf_req/cf_ack
  // --------------------------------------------------------------------------
  req_held: assert property (@(posedge g_clk) disable iff (reset)
    cf_req && !cf_ack |=> cf_req)
    else begin
      $error("cf_req dropped before cf_ack arrived");
      fail_count++;
    end

  req_release: assert property (@(posedge g_clk) disable iff (reset)
    cf_req && cf_ack |=> !cf_req)
    else begin
      $error("cf_req still high after cf_ack");
      fail_count++;
    end

  target_stable: assert property (@(posedge g_clk) disable iff (reset)
    cf_req && !cf_ack |=> $stable(cf_target))
    else begin
      $error("cf_target changed while cf_req was pending");
      fail_count++;
    end

  no_rise_on_ack: assert property (@(posedge g_clk) disable iff (reset)
    $rose(cf_req) |-> !cf_ack)
    else begin
      $error("cf_req raised while cf_ack still high");
      fail_count++;
    end

  // Nothing retires behind an unacknowledged request
  no_retire_waiting: assert property (@(posedge g_clk) disable iff (reset)
    cf_req && !cf_ack |-> !trs_valid)
    else begin
      $error("trs_valid high while cf_req waits for cf_ack");
      fail_count++;
    end

endmodule

/* sim/tb_frv_pipeline_back.sv */
`timescale 1ns/1ps

module tb_frv_pipeline_back;

  localparam int NUM_ITEMS  = 400;
  localparam int WAIT_LIMIT = 200;            // Cycles per bounded wait

  typedef struct packed {
    frv_pkg::xword_t   pc;
    frv_pkg::reg_idx_t rd;
    frv_pkg::xword_t   wdata;
    logic              wen;
    logic              taken;
    frv_pkg::xword_t   target;
    logic              is_branch;             // No link value to compare
  } retire_rec_t;

  logic                g_clk;
  logic                reset;
  logic                s2_p_valid;
  logic                s2_p_busy;
  frv_pkg::reg_idx_t   s2_rd;
  frv_pkg::reg_idx_t   s2_rs1;
  frv_pkg::reg_idx_t   s2_rs2;
  frv_pkg::xword_t     s2_imm;
  frv_pkg::xword_t     s2_pc;
  frv_pkg::uop_t       s2_uop;
  frv_pkg::fu_t        s2_fu;
  frv_pkg::opr_src_t   s2_opr_src;
  logic                cf_req;
  logic                cf_ack;
  frv_pkg::xword_t     cf_target;
  logic                trs_valid;
  frv_pkg::xword_t     trs_pc;
  frv_pkg::reg_idx_t   trs_rd;
  frv_pkg::xword_t     trs_wdata;
  logic                trs_wen;

  integer              seed;
  int                  errors;
  int                  accept_count;
  int                  retire_count;
  logic                hung = 1'b0;           // Some bounded wait ran out
  frv_pkg::xword_t     model_regs [0:31];     // Architectural state of the model
  retire_rec_t         exp_q [$];             // Expected retire order

  frv_pkg::uop_t alu_ops [10] = '{frv_pkg::UOP_ADD, frv_pkg::UOP_SUB, frv_pkg::UOP_AND,
                                  frv_pkg::UOP_OR, frv_pkg::UOP_XOR, frv_pkg::UOP_SLT,
                                  frv_pkg::UOP_SLTU, frv_pkg::UOP_SLL, frv_pkg::UOP_SRL,
                                  frv_pkg::UOP_SRA};
  frv_pkg::uop_t cf_ops [5]   = '{frv_pkg::UOP_BEQ, frv_pkg::UOP_BNE, frv_pkg::UOP_BLT,
                                  frv_pkg::UOP_BGE, frv_pkg::UOP_JAL};

  frv_pipeline_back dut0 (.*);

  bind frv_pipeline_back frv_back_checker checker0 (
    .g_clk(g_clk), .reset(reset), .cf_req(cf_req), .cf_ack(cf_ack),
    .cf_target(cf_target), .trs_valid(trs_valid)
  );

  initial begin
    g_clk = 1'b0;
    forever #10 g_clk = ~g_clk;               // 20 ns period
  end

  // --------------------------------------------------------------------------
  // Reference model, RV32 rules
  // --------------------------------------------------------------------------
  function automatic logic signed_less(frv_pkg::xword_t a, frv_pkg::xword_t b);
    return (a[31] != b[31]) ? a[31] : (a < b);   // Sign bits decide first
  endfunction

  function automatic frv_pkg::xword_t alu_model(frv_pkg::uop_t op, frv_pkg::xword_t a,
                                                frv_pkg::xword_t b);
    case (op)
      frv_pkg::UOP_ADD:  return a + b;
      frv_pkg::UOP_SUB:  return a - b;
      frv_pkg::UOP_AND:  return a & b;
      frv_pkg::UOP_OR:   return a | b;
      frv_pkg::UOP_XOR:  return a ^ b;
      frv_pkg::UOP_SLT:  return {31'b0, signed_less(a, b)};
      frv_pkg::UOP_SLTU: return {31'b0, a < b};
      frv_pkg::UOP_SLL:  return a << b[4:0];  // Shamt from low 5 bits
      frv_pkg::UOP_SRL:  return a >> b[4:0];
      frv_pkg::UOP_SRA:  return a[31] ? ((a >> b[4:0]) | ~(32'hffff_ffff >> b[4:0]))
                                      : (a >> b[4:0]);
      default:           return '0;
    endcase
  endfunction

  function automatic logic branch_model(frv_pkg::uop_t op, frv_pkg::xword_t a,
                                        frv_pkg::xword_t b);
    case (op)
      frv_pkg::UOP_BEQ: return a == b;
      frv_pkg::UOP_BNE: return a != b;
      frv_pkg::UOP_BLT: return signed_less(a, b);
      frv_pkg::UOP_BGE: return !signed_less(a, b);
      default:          return 1'b1;          // JAL
    endcase
  endfunction

  task automatic model_accept();
    frv_pkg::xword_t a;
    frv_pkg::xword_t b;
    retire_rec_t     rec;
    a = '0;
    if (s2_opr_src[frv_pkg::OPR_A_RS1]) begin
      a = model_regs[s2_rs1];
    end else if (s2_opr_src[frv_pkg::OPR_A_PC]) begin
      a = s2_pc;
    end
    b = '0;
    if (s2_opr_src[frv_pkg::OPR_B_RS2]) begin
      b = model_regs[s2_rs2];
    end else if (s2_opr_src[frv_pkg::OPR_B_IMM]) begin
      b = s2_imm;
    end
    rec.pc        = s2_pc;
    rec.rd        = s2_rd;
    rec.target    = s2_pc + s2_imm;
    rec.is_branch = s2_fu[frv_pkg::FU_CFU] && s2_uop != frv_pkg::UOP_JAL;
    rec.taken     = s2_fu[frv_pkg::FU_CFU] && branch_model(s2_uop, a, b);
    rec.wdata     = s2_fu[frv_pkg::FU_CFU] ? s2_pc + 32'd4 : alu_model(s2_uop, a, b);
    rec.wen       = !rec.is_branch && s2_rd != '0;   // x0 never written
    if (rec.wen) begin
      model_regs[s2_rd] = rec.wdata;
    end
    exp_q.push_back(rec);
    accept_count++;
  endtask

  // --------------------------------------------------------------------------
  // Checks and run control
  // --------------------------------------------------------------------------
  task automatic compare_field(string name, logic [31:0] expected, logic [31:0] actual);
    assert (expected == actual) else begin
      errors++;
      $display("FAIL at %0d ns: %s expected %h, actual %h", $time, name, expected, actual);
    end
  endtask

  task automatic finish_run();
    int total;
    total = errors + dut0.checker0.fail_count;
    $display("Errors: %0d (model checks %0d, assertions %0d), accepted %0d, retired %0d",
             total, errors, dut0.checker0.fail_count, accept_count, retire_count);
    if (total == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  endtask

  task automatic report_timeout(string what);
    errors++;
    hung = 1'b1;                              // Main flow stops issuing
    $display("Timeout at %0d ns: %s", $time, what);
  endtask

  task automatic check_retire();
    retire_rec_t want;
    retire_count++;
    assert (exp_q.size() > 0) else begin
      errors++;
      $display("Retire at %0d ns with no accepted instruction outstanding", $time);
    end
    if (exp_q.size() > 0) begin
      want = exp_q.pop_front();
      compare_field("trs_pc", want.pc, trs_pc);
      compare_field("trs_rd", 32'(want.rd), 32'(trs_rd));
      compare_field("trs_wen", 32'(want.wen), 32'(trs_wen));
      if (!want.is_branch) begin
        compare_field("trs_wdata", want.wdata, trs_wdata);  // ALU result or link
      end
      compare_field("cf_req", 32'(want.taken), 32'(cf_req));
      if (want.taken) begin
        compare_field("cf_target", want.target, cf_target);
      end
    end
  endtask

  // Retire monitor, outputs settled mid cycle
  initial begin
    forever begin
      @(negedge g_clk);
      if (!reset && trs_valid) begin
        check_retire();
      end
    end
  end

  // Four-phase responder, ack after 0 to 10 cycles
  initial begin
    int delay;
    int waited;
    while (!hung) begin
      @(negedge g_clk);
      if (!reset && cf_req) begin
        delay = int'($unsigned($random(seed)) % 11);
        repeat (delay) @(posedge g_clk);
        @(posedge g_clk);
        #2;
        cf_ack = 1'b1;
        waited = 0;
        @(negedge g_clk);
        while (cf_req && waited < WAIT_LIMIT) begin
          @(negedge g_clk);
          waited++;
        end
        if (cf_req) begin
          report_timeout("cf_req never dropped after cf_ack");
        end else begin
          @(posedge g_clk);
          #2;
          cf_ack = 1'b0;                      // Release phase
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // Frontend stimulus
  // --------------------------------------------------------------------------
  task automatic load_item();
    logic [31:0] r;
    int          k;
    r          = $random(seed);
    s2_rs1     = {2'b00, r[2:0]};             // x0..x7 for frequent hazards
    s2_rs2     = {2'b00, r[5:3]};
    s2_imm     = $random(seed);
    s2_pc      = $random(seed) & 32'hffff_fffc;
    s2_fu      = '0;
    s2_opr_src = '0;
    if (r[31:24] < 8'd51) begin               // About one in five
      k      = int'(r[15:9]) % 5;
      s2_uop = cf_ops[k];
      s2_fu[frv_pkg::FU_CFU] = 1'b1;
      s2_rd  = (s2_uop == frv_pkg::UOP_JAL) ? {2'b00, r[8:6]} : 5'd0;
      s2_opr_src[frv_pkg::OPR_A_RS1] = 1'b1;
      s2_opr_src[frv_pkg::OPR_B_RS2] = 1'b1;
    end else begin
      k      = int'(r[15:9]) % 10;
      s2_uop = alu_ops[k];
      s2_fu[frv_pkg::FU_ALU] = 1'b1;
      s2_rd  = {2'b00, r[8:6]};
      s2_opr_src[r[17:16] == 2'b00 ? frv_pkg::OPR_A_PC : frv_pkg::OPR_A_RS1] = 1'b1;
      s2_opr_src[r[18] ? frv_pkg::OPR_B_IMM : frv_pkg::OPR_B_RS2] = 1'b1;
    end
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (retire_count < accept_count && waited < WAIT_LIMIT) begin
      @(posedge g_clk);
      #2;
      waited++;
    end
    if (retire_count < accept_count) begin
      report_timeout("accepted instructions never retired");
    end
  endtask

  task automatic issue_item();
    int   waited;
    logic is_cf;
    load_item();
    is_cf      = s2_fu[frv_pkg::FU_CFU];
    s2_p_valid = 1'b1;
    waited     = 0;
    @(negedge g_clk);
    while (s2_p_busy && waited < WAIT_LIMIT) begin
      @(negedge g_clk);
      waited++;
    end
    if (s2_p_busy) begin
      report_timeout("s2_p_busy stayed high, instruction never accepted");
    end else begin
      model_accept();                         // Taken at the coming edge
      @(posedge g_clk);
      #2;
      s2_p_valid = 1'b0;
      if (is_cf) begin
        wait_drained();                       // No issue past a branch until resolved
      end
    end
  endtask

  initial begin
    logic [31:0] r;
    int          gap;
    seed         = 54584;
    errors       = 0;
    accept_count = 0;
    retire_count = 0;
    reset        = 1'b1;
    cf_ack       = 1'b0;
    s2_p_valid   = 1'b0;
    s2_rd        = '0;
    s2_rs1       = '0;
    s2_rs2       = '0;
    s2_imm       = '0;
    s2_pc        = '0;
    s2_uop       = '0;
    s2_fu        = '0;
    s2_opr_src   = '0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    repeat (3) @(posedge g_clk);
    #2;
    reset = 1'b0;
    @(negedge g_clk);
    compare_field("s2_p_busy", 32'd0, 32'(s2_p_busy));   // Idle after reset
    compare_field("cf_req", 32'd0, 32'(cf_req));
    compare_field("trs_valid", 32'd0, 32'(trs_valid));
    @(posedge g_clk);
    #2;
    for (int n = 0; n < NUM_ITEMS && !hung; n++) begin
      r   = $random(seed);
      gap = (r[1:0] == 2'b00) ? int'(r[3:2]) + 1 : 0;    // Mostly back to back
      repeat (gap) begin
        @(posedge g_clk);
        #2;
      end
      issue_item();
    end
    if (!hung) begin
      wait_drained();
    end
    if (!hung) begin
      compare_field("retire_count", 32'(accept_count), 32'(retire_count));  // Surplus retires
    end
    finish_run();
  end

endmodule

/* build.f */
hdl/frv_pkg.sv
hdl/frv_stage_if.sv
hdl/frv_result_if.sv
hdl/frv_gprs.sv
hdl/frv_pipeline_dispatch.sv
hdl/frv_pipeline_execute.sv
hdl/frv_pipeline_writeback.sv
hdl/frv_pipeline_back.sv
sim/frv_back_checker.sv
sim/tb_frv_pipeline_back.sv

/* run.sh */
#!/bin/sh
# Compile and run the backend testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f \
  --top-module tb_frv_pipeline_back -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "Simulation PASSED"; then
  exit 0
fi
exit 1
